//--- bench/qupls_fetch_assertions.sv
`timescale 1ns/1ps
`include "qupls_consts.svh"

// ============================================================
// Fetch front end checker, bound into the top level
// ============================================================

module qupls_fetch_assertions (
	input logic                           clk,
	input logic                           rst_n_i,
	input logic                           fetch_i,
	input qupls_fetch_pkg::pc_address_t   pc_i,
	input logic                           fetch_ready_o,
	input logic [`QUPLS_LINE_ADDR_W-1:0]  mem_addr_o,
	input logic                           mem_rd_o,
	input logic [`QUPLS_LINE_BYTES*8-1:0] mem_data_i,
	input qupls_decode_pkg::len_group_t   group_o,
	input logic                           group_valid_o,
	input logic                           group_pop_i,
	input logic                           lq_push,
	input logic                           lq_full,
	input logic                           lq_pop,
	input logic                           gq_push,
	input logic [$clog2(`QUPLS_QUEUE_DEPTH):0] gq_free
);

	localparam int OFF_W = $clog2(`QUPLS_LINE_BYTES);
	// Accept, read, return and push, pop, two decode stages, group push
	localparam int GROUP_LAT = 6;
	// Line side and group side each hold at most one queue depth
	localparam int MAX_OUT = 2 * `QUPLS_QUEUE_DEPTH;

	// Failures seen so far, read by the testbench for its summary
	int err_count = 0;

	// Reference queue of accepted PCs and the lines returned for them
	qupls_fetch_pkg::pc_address_t pc_ref [16];
	logic [`QUPLS_LINE_BYTES*8-1:0] line_ref [16];
	logic [4:0] pc_wr;
	logic [4:0] pc_rd;
	logic [4:0] line_wr;
	logic [4:0] outstanding;
	logic accept;
	logic take;
	logic acc_d;
	logic rd_d;
	logic [2:0] lat_cnt;
	logic [2:0] lq_cnt;
	logic [2:0] gq_cnt;
	qupls_fetch_pkg::pc_address_t acc_pc;
	qupls_fetch_pkg::pc_address_t exp_pc;
	logic [`QUPLS_LINE_BYTES*8-1:0] exp_line;
	logic [`QUPLS_NSLOT*`QUPLS_LEN_W-1:0] exp_lens;

	// Walk the line from the PC offset, each instruction being 2 x (opcode[1:0] + 1) bytes
	function automatic logic [`QUPLS_NSLOT*`QUPLS_LEN_W-1:0] ref_lengths(
			input logic [`QUPLS_LINE_BYTES*8-1:0] line, input qupls_fetch_pkg::pc_address_t pc);
		int off;
		logic [7:0] opc;
		logic [`QUPLS_LEN_W-1:0] len;
		ref_lengths = '0;
		off = int'(pc % `QUPLS_LINE_BYTES);
		for (int s = 0; s < `QUPLS_NSLOT; s++) begin
			opc = line[off*8 +: 8];
			len = `QUPLS_LEN_W'((opc % 8'd4 + 8'd1) * 8'd2);
			ref_lengths[s*`QUPLS_LEN_W +: `QUPLS_LEN_W] = len;
			// No spill into the next line, the offset wraps
			off = (off + int'(len)) % `QUPLS_LINE_BYTES;
		end
	endfunction

	assign accept = fetch_i & fetch_ready_o;
	assign take = group_valid_o & group_pop_i;
	assign outstanding = pc_wr - pc_rd;
	assign exp_pc = pc_ref[pc_rd[3:0]];
	assign exp_line = line_ref[pc_rd[3:0]];
	assign exp_lens = ref_lengths(exp_line, exp_pc);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_wr <= '0;
			pc_rd <= '0;
			line_wr <= '0;
			acc_d <= 1'b0;
			rd_d <= 1'b0;
			lat_cnt <= '0;
			lq_cnt <= '0;
			gq_cnt <= '0;
		end else begin
			acc_d <= accept;
			rd_d <= mem_rd_o;
			if (accept) begin
				acc_pc <= pc_i;
				pc_ref[pc_wr[3:0]] <= pc_i;
				pc_wr <= pc_wr + 5'd1;
			end
			// Memory data is valid the cycle after the read strobe
			if (rd_d) begin
				line_ref[line_wr[3:0]] <= mem_data_i;
				line_wr <= line_wr + 5'd1;
			end
			if (take) begin
				pc_rd <= pc_rd + 5'd1;
			end
			// Queue occupancy as counted from the strobes at each queue
			lq_cnt <= lq_cnt + 3'(lq_push) - 3'(lq_pop);
			gq_cnt <= gq_cnt + 3'(gq_push) - 3'(group_pop_i);
			// A fetch into an idle front end starts the latency countdown
			if (accept && pc_wr == pc_rd) begin
				lat_cnt <= 3'(GROUP_LAT + 1);
			end else if (lat_cnt != 0) begin
				lat_cnt <= lat_cnt - 3'd1;
			end
		end
	end

	a_reset_state: assert property (@(posedge clk) $rose(rst_n_i) |->
			!mem_rd_o && !group_valid_o && fetch_ready_o)
		else begin
			err_count++;
			$error("Outputs were not in their idle state after reset");
		end

	a_read_addr: assert property (@(posedge clk) disable iff (!rst_n_i)
			acc_d |-> mem_rd_o && mem_addr_o == acc_pc[`QUPLS_PC_W-1:OFF_W])
		else begin
			err_count++;
			$error("FAIL %0t mem_addr_o got %h expected %h with mem_rd_o %b", $time,
				$sampled(mem_addr_o), $sampled(acc_pc[`QUPLS_PC_W-1:OFF_W]), $sampled(mem_rd_o));
		end

	a_read_cause: assert property (@(posedge clk) disable iff (!rst_n_i) mem_rd_o |-> acc_d)
		else begin
			err_count++;
			$error("A line read was issued without an accepted fetch");
		end

	a_lone_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
			lat_cnt > 3'd1 |-> !group_valid_o)
		else begin
			err_count++;
			$error("FAIL %0t group_valid_o got 1 expected 0", $time);
		end

	a_lone_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
			lat_cnt == 3'd1 |-> group_valid_o)
		else begin
			err_count++;
			$error("FAIL %0t group_valid_o got 0 expected 1", $time);
		end

	a_group_known: assert property (@(posedge clk) disable iff (!rst_n_i)
			take |-> outstanding != 0)
		else begin
			err_count++;
			$error("A group came out with no fetch waiting for it");
		end

	a_group_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
			take |-> group_o.pc == exp_pc)
		else begin
			err_count++;
			$error("FAIL %0t group_o.pc got %h expected %h", $time,
				$sampled(group_o.pc), $sampled(exp_pc));
		end

	a_group_line: assert property (@(posedge clk) disable iff (!rst_n_i)
			take |-> group_o.line == exp_line)
		else begin
			err_count++;
			$error("FAIL %0t group_o.line got %h expected %h", $time,
				$sampled(group_o.line), $sampled(exp_line));
		end

	a_group_lens: assert property (@(posedge clk) disable iff (!rst_n_i)
			take |-> group_o.lengths == exp_lens)
		else begin
			err_count++;
			$error("FAIL %0t group_o.lengths got %h expected %h", $time,
				$sampled(group_o.lengths), $sampled(exp_lens));
		end

	// Back-pressure must stop fetching before anything can be dropped
	a_cap: assert property (@(posedge clk) disable iff (!rst_n_i)
			outstanding < 5'(MAX_OUT) || (outstanding == 5'(MAX_OUT) && !fetch_ready_o))
		else begin
			err_count++;
			$error("FAIL %0t outstanding got %0d expected at most %0d with fetch_ready_o low",
				$time, $sampled(outstanding), MAX_OUT);
		end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
			!(lq_push && lq_full) && !(gq_push && gq_free == 0))
		else begin
			err_count++;
			$error("A queue was pushed while it was full");
		end

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i)
			!(lq_pop && lq_cnt == 3'd0) && !(group_pop_i && gq_cnt == 3'd0))
		else begin
			err_count++;
			$error("A queue was popped while it was empty");
		end

endmodule

bind qupls_fetch_top qupls_fetch_assertions u_checks (
	.clk(clk), .rst_n_i(rst_n_i), .fetch_i(fetch_i), .pc_i(pc_i),
	.fetch_ready_o(fetch_ready_o), .mem_addr_o(mem_addr_o), .mem_rd_o(mem_rd_o),
	.mem_data_i(mem_data_i), .group_o(group_o), .group_valid_o(group_valid_o),
	.group_pop_i(group_pop_i), .lq_push(lq_push), .lq_full(lq_full), .lq_pop(lq_pop),
	.gq_push(gq_push), .gq_free(gq_free)
);

//--- bench/qupls_fetch_tb.sv
`timescale 1ns/1ps
`include "qupls_consts.svh"

// ============================================================
// Fetch front end testbench
// ============================================================

module qupls_fetch_tb;

	// Tests take well under 400 cycles, the rest is margin
	localparam int CYCLE_LIMIT = 600;
	localparam int NLINE = 16;

	logic clk;
	logic rst_n_i;
	logic fetch_i;
	qupls_fetch_pkg::pc_address_t pc_i;
	logic fetch_ready_o;
	logic [`QUPLS_LINE_ADDR_W-1:0] mem_addr_o;
	logic mem_rd_o;
	logic [`QUPLS_LINE_BYTES*8-1:0] mem_data_i;
	qupls_decode_pkg::len_group_t group_o;
	logic group_valid_o;
	logic group_pop_i;

	// Instruction memory model
	logic [`QUPLS_LINE_BYTES*8-1:0] line_mem [NLINE];
	logic rd_seen;
	logic [3:0] addr_seen;
	integer seed;
	int cycles;
	int accepted;
	int popped;
	int other_errors;
	int last_total;
	logic auto_pop;

	qupls_fetch_top dut_i (
		.clk(clk), .rst_n_i(rst_n_i), .fetch_i(fetch_i), .pc_i(pc_i),
		.fetch_ready_o(fetch_ready_o), .mem_addr_o(mem_addr_o), .mem_rd_o(mem_rd_o),
		.mem_data_i(mem_data_i), .group_o(group_o), .group_valid_o(group_valid_o),
		.group_pop_i(group_pop_i)
	);

	always #20 clk = ~clk;

	// The read seen in one cycle is answered in the next
	always @(posedge clk) begin
		#2;
		mem_data_i = rd_seen ? line_mem[addr_seen] : '0;
		rd_seen = mem_rd_o;
		addr_seen = mem_addr_o[3:0];
	end

	// Pops the head group whenever popping is enabled and a group is there
	always @(posedge clk) begin
		#2;
		group_pop_i = auto_pop & group_valid_o;
		if (group_pop_i) begin
			popped++;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Run stopped at the limit of %0d cycles before the tests ended", CYCLE_LIMIT);
		$display("** FAIL **");
		$finish;
	end

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	function automatic int total_errors();
		return dut_i.u_checks.err_count + other_errors;
	endfunction

	// Waits for room, then holds the request for exactly one cycle
	task automatic issue_fetch(input int max_wait, output logic took);
		int waited;
		waited = 0;
		while (!fetch_ready_o && waited < max_wait) begin
			step();
			waited++;
		end
		took = fetch_ready_o;
		if (took) begin
			fetch_i = 1'b1;
			pc_i = $random(seed) & 32'h0000_03ff;
			step();
			fetch_i = 1'b0;
			accepted++;
		end
	endtask

	// Issues a fetch that the front end has to take within the wait
	task automatic issue_required_fetch(input int max_wait);
		logic took;
		issue_fetch(max_wait, took);
		if (!took) begin
			other_errors++;
			$display("fetch_ready_o stayed low for %0d cycles and the fetch was not taken",
				max_wait);
		end
	endtask

	task automatic wait_drained(input int max_wait);
		int waited;
		waited = 0;
		while (popped < accepted && waited < max_wait) begin
			step();
			waited++;
		end
		if (popped < accepted) begin
			other_errors++;
			$display("Only %0d of %0d groups came out in time", popped, accepted);
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s done, %0d new errors", num, name, total_errors() - last_total);
		last_total = total_errors();
	endtask

	initial begin
		logic took;
		int tries;
		clk = 1'b0;
		rst_n_i = 1'b0;
		fetch_i = 1'b0;
		pc_i = '0;
		mem_data_i = '0;
		group_pop_i = 1'b0;
		auto_pop = 1'b0;
		rd_seen = 1'b0;
		addr_seen = '0;
		accepted = 0;
		popped = 0;
		other_errors = 0;
		last_total = 0;
		seed = 32'hdbffbaf8;
		for (int i = 0; i < NLINE; i++) begin
			for (int w = 0; w < `QUPLS_LINE_BYTES / 4; w++) begin
				line_mem[i][w*32 +: 32] = $random(seed);
			end
		end
		repeat (8) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		step();

		// A lone fetch into an idle front end exercises the latency checks
		auto_pop = 1'b1;
		issue_required_fetch(10);
		wait_drained(30);
		end_test(1, "single fetch");

		// Fetches go in as fast as the fetcher takes them
		for (int i = 0; i < 6; i++) begin
			issue_required_fetch(10);
		end
		wait_drained(40);
		end_test(2, "back-to-back fetches");

		// With no pops both queues fill and fetch_ready_o must stay low
		auto_pop = 1'b0;
		took = 1'b1;
		tries = 0;
		while (took && tries < 12) begin
			issue_fetch(8, took);
			tries++;
		end
		if (took) begin
			other_errors++;
			$display("fetch_ready_o never fell while group_pop_i was held low");
		end
		repeat (4) step();
		end_test(3, "back-pressure");

		auto_pop = 1'b1;
		wait_drained(60);
		repeat (4) step();
		end_test(4, "drain");

		$display("Fetches %0d, groups %0d, assertion errors %0d, other errors %0d",
			accepted, popped, dut_i.u_checks.err_count, other_errors);
		if (total_errors() == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- qupls_fetch_top.f
+incdir+verilog
verilog/qupls_fetch_pkg.sv
verilog/qupls_decode_pkg.sv
verilog/qupls_line_fetcher.sv
verilog/qupls_fetch_queue.sv
verilog/qupls_ins_lengths.sv
verilog/qupls_fetch_top.sv
bench/qupls_fetch_assertions.sv
bench/qupls_fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the fetch front end testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f qupls_fetch_top.f \
	--top-module qupls_fetch_tb -o qupls_fetch_sim > build.log 2>&1 \
	&& ./obj_dir/qupls_fetch_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verilog/qupls_consts.svh
`ifndef QUPLS_CONSTS_SVH
`define QUPLS_CONSTS_SVH

// ============================================================
// Fetch front end sizing
// ============================================================

// Bytes in one instruction line as read from the instruction memory
`define QUPLS_LINE_BYTES 64

// Width of the program counter
`define QUPLS_PC_W 32

// Width of one decoded instruction length in bytes
`define QUPLS_LEN_W 5

// Number of chained instruction lengths decoded from each line
`define QUPLS_NSLOT 6

// Entries held by each fetch queue
`define QUPLS_QUEUE_DEPTH 4

// Width of a line address, which is the PC with the byte offset dropped
`define QUPLS_LINE_ADDR_W 26

`endif

//--- verilog/qupls_decode_pkg.sv
`include "qupls_consts.svh"

// ============================================================
// Types that describe the decode side of the front end
// ============================================================

package qupls_decode_pkg;

	// Length of one instruction in bytes, which is 2, 4, 6 or 8
	typedef logic [`QUPLS_LEN_W-1:0] ins_len_t;

	// A decoded group leaves the length decoder as one record
	// The line and PC travel along so later stages can extract the
	// instruction bytes without another memory read
	typedef struct packed {
		qupls_fetch_pkg::pc_address_t pc;
		// Raw line bytes with byte 0 in the low eight bits
		logic [`QUPLS_LINE_BYTES*8-1:0] line;
		// Slot 0 holds the instruction at the PC offset
		// Each higher slot holds the instruction that follows the slot below
		ins_len_t [`QUPLS_NSLOT-1:0] lengths;
	} len_group_t;

endpackage

//--- verilog/qupls_fetch_pkg.sv
`include "qupls_consts.svh"

// ============================================================
// Types that describe the fetch side of the front end
// ============================================================

package qupls_fetch_pkg;

	// Program counter as carried through fetch and decode
	typedef logic [`QUPLS_PC_W-1:0] pc_address_t;

	// One fetched line together with the PC that requested it
	// The PC keeps its byte offset so the decoder knows where the first
	// instruction starts within the line
	typedef struct packed {
		pc_address_t pc;
		// Byte 0 of the line sits in the low eight bits
		logic [`QUPLS_LINE_BYTES*8-1:0] line;
	} fetch_line_t;

endpackage

//--- verilog/qupls_fetch_queue.sv
`timescale 1ns/1ps
`include "qupls_consts.svh"

// ============================================================
// Fetch queue
// ============================================================

// Small synchronous FIFO built as a circular buffer
// The entry type is a parameter so the same queue holds fetched lines
// between fetcher and decoder and decoded groups at the output
module qupls_fetch_queue #(
	parameter type entry_t = logic
) (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic                                push_i,
	input  entry_t                              data_i,
	input  logic                                pop_i,
	output entry_t                              data_o,
	output logic                                empty_o,
	output logic                                full_o,
	output logic [$clog2(`QUPLS_QUEUE_DEPTH):0] free_o
);

	localparam int DEPTH = `QUPLS_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	// Entry storage
	entry_t mem [DEPTH];
	// Pointers wrap at the depth, which is a power of two
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	// Occupancy needs one more bit than the pointers to tell full from empty
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// Requests that would overflow or underflow are dropped here
	assign do_push = push_i & ~full_o;
	assign do_pop = pop_i & ~empty_o;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// A push and a pop together leave the count as it is
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Write the new entry at the tail
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

	// The head is read without a register so a pushed entry shows right after the edge
	assign data_o = mem[rd_ptr];
	assign empty_o = (count == '0);
	assign full_o = (count == CNT_W'(DEPTH));
	assign free_o = CNT_W'(DEPTH) - count;

endmodule

//--- verilog/qupls_fetch_top.sv
`timescale 1ns/1ps
`include "qupls_consts.svh"

// ============================================================
// Fetch front end top level
// ============================================================

// Fetcher feeds the line queue, the decoder drains it into the group queue,
// and the outside pops groups from the group queue
module qupls_fetch_top (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic                                fetch_i,
	input  qupls_fetch_pkg::pc_address_t        pc_i,
	output logic                                fetch_ready_o,
	output logic [`QUPLS_LINE_ADDR_W-1:0]       mem_addr_o,
	output logic                                mem_rd_o,
	input  logic [`QUPLS_LINE_BYTES*8-1:0]      mem_data_i,
	output qupls_decode_pkg::len_group_t        group_o,
	output logic                                group_valid_o,
	input  logic                                group_pop_i
);

	// Between fetcher and line queue
	logic lq_push;
	logic lq_full;
	qupls_fetch_pkg::fetch_line_t lq_in;
	// Between line queue and decoder
	logic lq_pop;
	logic lq_empty;
	qupls_fetch_pkg::fetch_line_t lq_head;
	// Between decoder and group queue
	logic gq_push;
	logic gq_empty;
	logic [$clog2(`QUPLS_QUEUE_DEPTH):0] gq_free;
	qupls_decode_pkg::len_group_t gq_in;

	qupls_line_fetcher u_fetcher (
		.clk(clk), .rst_n_i(rst_n_i), .fetch_i(fetch_i), .pc_i(pc_i),
		.mem_data_i(mem_data_i), .full_i(lq_full), .fetch_ready_o(fetch_ready_o),
		.mem_rd_o(mem_rd_o), .mem_addr_o(mem_addr_o), .push_o(lq_push), .line_o(lq_in)
	);

	// The decoder pops by credit, so this queue's free count is not needed
	qupls_fetch_queue #(.entry_t(qupls_fetch_pkg::fetch_line_t)) u_line_queue (
		.clk(clk), .rst_n_i(rst_n_i), .push_i(lq_push), .data_i(lq_in), .pop_i(lq_pop),
		.data_o(lq_head), .empty_o(lq_empty), .full_o(lq_full), .free_o()
	);

	qupls_ins_lengths u_lengths (
		.clk(clk), .rst_n_i(rst_n_i), .line_i(lq_head), .empty_i(lq_empty),
		.free_i(gq_free), .pop_o(lq_pop), .push_o(gq_push), .group_o(gq_in)
	);

	// Credit flow keeps this queue from filling past its free count
	qupls_fetch_queue #(.entry_t(qupls_decode_pkg::len_group_t)) u_group_queue (
		.clk(clk), .rst_n_i(rst_n_i), .push_i(gq_push), .data_i(gq_in),
		.pop_i(group_pop_i), .data_o(group_o), .empty_o(gq_empty), .full_o(),
		.free_o(gq_free)
	);

	assign group_valid_o = ~gq_empty;

endmodule

//--- verilog/qupls_ins_lengths.sv
`timescale 1ns/1ps
`include "qupls_consts.svh"

// ============================================================
// Instruction length decoder
// ============================================================

// Finds the lengths of consecutive instructions in one line over three stages
// Stage 1 decodes a candidate length at every byte of the line
// Stage 2 walks the first half of the slots starting at the PC offset
// Stage 3 walks the rest and forms the group that is pushed at its end
// Lines are only popped when the output queue is sure to have room for them
module qupls_ins_lengths (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  qupls_fetch_pkg::fetch_line_t        line_i,
	input  logic                                empty_i,
	input  logic [$clog2(`QUPLS_QUEUE_DEPTH):0] free_i,
	output logic                                pop_o,
	output logic                                push_o,
	output qupls_decode_pkg::len_group_t        group_o
);

	localparam int NBYTE = `QUPLS_LINE_BYTES;
	localparam int OFF_W = $clog2(NBYTE);
	localparam int HALF = `QUPLS_NSLOT / 2;
	localparam int CNT_W = $clog2(`QUPLS_QUEUE_DEPTH) + 1;

	// Length of the instruction whose opcode has the given two low bits
	// Opcode 0 to 3 maps to 2, 4, 6 and 8 bytes
	function automatic qupls_decode_pkg::ins_len_t decode_len(input logic [1:0] opc);
		decode_len = qupls_decode_pkg::ins_len_t'({1'b0, opc} + 3'd1) << 1;
	endfunction

	// Candidate lengths for every byte of the incoming line
	qupls_decode_pkg::ins_len_t [NBYTE-1:0] byte_len;

	// Stage 1 registers
	logic s1_v;
	qupls_fetch_pkg::fetch_line_t s1_line;
	qupls_decode_pkg::ins_len_t [NBYTE-1:0] s1_blen;

	// Stage 2 registers
	logic s2_v;
	qupls_fetch_pkg::fetch_line_t s2_line;
	qupls_decode_pkg::ins_len_t [NBYTE-1:0] s2_blen;
	qupls_decode_pkg::ins_len_t [HALF-1:0] s2_head;
	logic [OFF_W-1:0] s2_sum;

	// Stage 3 registers
	logic s3_v;
	qupls_decode_pkg::len_group_t s3_group;

	// Chaining results between the registers
	qupls_decode_pkg::ins_len_t [HALF-1:0] head_len;
	qupls_decode_pkg::ins_len_t [HALF-1:0] tail_len;
	logic [OFF_W-1:0] head_off;
	logic [OFF_W-1:0] head_sum;
	logic [OFF_W-1:0] tail_off;
	logic [CNT_W-1:0] in_flight;

	// Every line in a stage will be pushed, so it already owns an output slot
	assign in_flight = CNT_W'(s1_v) + CNT_W'(s2_v) + CNT_W'(s3_v);
	assign pop_o = ~empty_i & (free_i > in_flight);

	// Only the two low bits of each byte matter for the length
	always_comb begin
		for (int b = 0; b < NBYTE; b++) begin
			byte_len[b] = decode_len(line_i.line[b*8 +: 2]);
		end
	end

	// Walk the first slots from the PC byte offset
	// Offsets wrap within the line and never spill into the next one
	always_comb begin
		head_off = s1_line.pc[OFF_W-1:0];
		head_sum = '0;
		for (int i = 0; i < HALF; i++) begin
			head_len[i] = s1_blen[head_off];
			head_off = head_off + OFF_W'(head_len[i]);
			head_sum = head_sum + OFF_W'(head_len[i]);
		end
	end

	// Resume the walk where the first half ended
	always_comb begin
		tail_off = s2_line.pc[OFF_W-1:0] + s2_sum;
		for (int i = 0; i < HALF; i++) begin
			tail_len[i] = s2_blen[tail_off];
			tail_off = tail_off + OFF_W'(tail_len[i]);
		end
	end

	// Valid bits follow each line down the pipe
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			s1_v <= 1'b0;
			s2_v <= 1'b0;
			s3_v <= 1'b0;
		end else begin
			s1_v <= pop_o;
			s2_v <= s1_v;
			s3_v <= s2_v;
		end
	end

	// Payload moves every cycle and is qualified by the valid bits
	always_ff @(posedge clk) begin
		s1_line <= line_i;
		s1_blen <= byte_len;
		s2_line <= s1_line;
		s2_blen <= s1_blen;
		s2_head <= head_len;
		s2_sum <= head_sum;
		s3_group.pc <= s2_line.pc;
		s3_group.line <= s2_line.line;
		// Upper slots come from this stage and lower slots from stage 2
		s3_group.lengths <= {tail_len, s2_head};
	end

	assign push_o = s3_v;
	assign group_o = s3_group;

endmodule

//--- verilog/qupls_line_fetcher.sv
`timescale 1ns/1ps
`include "qupls_consts.svh"

// ============================================================
// Line fetcher
// ============================================================

// Takes one fetch request at a time and reads the aligned line for it
// The returned line is paired with the requesting PC and pushed into the
// fetch queue one cycle after the read strobe
module qupls_line_fetcher (
	input  logic                                clk,
	input  logic                                rst_n_i,
	input  logic                                fetch_i,
	input  qupls_fetch_pkg::pc_address_t        pc_i,
	input  logic [`QUPLS_LINE_BYTES*8-1:0]      mem_data_i,
	input  logic                                full_i,
	output logic                                fetch_ready_o,
	output logic                                mem_rd_o,
	output logic [`QUPLS_LINE_ADDR_W-1:0]       mem_addr_o,
	output logic                                push_o,
	output qupls_fetch_pkg::fetch_line_t        line_o
);

	// Number of PC bits that address a byte within a line
	localparam int OFF_W = $clog2(`QUPLS_LINE_BYTES);

	// High in the cycle that the read strobe is out
	logic rd_q;
	// High in the cycle that the memory returns the line
	logic wait_q;
	// PC of the request being served
	qupls_fetch_pkg::pc_address_t pc_q;
	logic accept;

	// A new request is taken only when nothing is pending and the queue has room
	// Since only this block pushes, the room seen here is still there at the push
	assign fetch_ready_o = ~rd_q & ~wait_q & ~full_i;
	assign accept = fetch_i & fetch_ready_o;

	// The read and return phases each last one cycle
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_q <= 1'b0;
			wait_q <= 1'b0;
		end else begin
			rd_q <= accept;
			wait_q <= rd_q;
		end
	end

	// Hold the PC until the line comes back
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_q <= pc_i;
		end
	end

	// The memory is addressed by line so the byte offset is dropped
	assign mem_rd_o = rd_q;
	assign mem_addr_o = pc_q[`QUPLS_PC_W-1:OFF_W];

	// The line is valid during the return cycle and the queue captures it
	assign push_o = wait_q;
	assign line_o = '{pc: pc_q, line: mem_data_i};

endmodule
